// File: include/axi_wr_defs.svh
`ifndef AXI_WR_DEFS_SVH
`define AXI_WR_DEFS_SVH

// --------------------
// Bus widths
// --------------------
`define DATA_W      64
`define ADDR_W      32
`define ID_W        2
`define USER_W      8

// --------------------
// Block and burst geometry
// --------------------
// Beats per block, awlen is one less
`define BURST_LEN   4
`define BLOCK_BYTES 32

// Beats held by the block FIFO
`define FIFO_DEPTH  16

`endif

// File: hdl/axi_wr_pkg.sv
`default_nettype none

package axi_wr_pkg;

    // Address channel FSM
    typedef enum logic [1:0] {
        ADDR_IDLE,
        ADDR_ISSUE,
        ADDR_DRAIN
    } addr_state_t;

    // Data channel FSM
    typedef enum logic {
        DATA_IDLE,
        DATA_BURST
    } data_state_t;

    // AXI write response codes
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } bresp_t;

endpackage

`default_nettype wire

// File: hdl/block_fifo.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_wr_defs.svh"

module block_fifo (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               push,
    input  logic [`DATA_W-1:0] push_data,
    output logic               full,
    input  logic               fifo_rd,
    output logic [`DATA_W-1:0] fifo_dout,
    output logic               fifo_empty
);

    localparam int               PTR_W    = $clog2(`FIFO_DEPTH);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`FIFO_DEPTH - 1);
    localparam logic [PTR_W:0]   DEPTH_C  = (PTR_W + 1)'(`FIFO_DEPTH);

    logic [`DATA_W-1:0] mem [`FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [PTR_W:0]     count_q;
    logic               wr_en;
    logic               rd_en;

    assign full       = (count_q == DEPTH_C);
    assign fifo_empty = (count_q == '0);
    // Head beat visible before the pop
    assign fifo_dout  = mem[rd_ptr_q];

    assign wr_en = push && !full;
    assign rd_en = fifo_rd && !fifo_empty;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end
        else
        begin
            if (wr_en)
                wr_ptr_q <= (wr_ptr_q == LAST_PTR) ? '0 : wr_ptr_q + 1'b1;
            if (rd_en)
                rd_ptr_q <= (rd_ptr_q == LAST_PTR) ? '0 : rd_ptr_q + 1'b1;
            if (wr_en && !rd_en)
                count_q <= count_q + 1'b1;
            else if (rd_en && !wr_en)
                count_q <= count_q - 1'b1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wr_en)
            mem[wr_ptr_q] <= push_data;
    end

endmodule

`default_nettype wire

// File: hdl/waddr_channel.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_wr_defs.svh"

module waddr_channel (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_pulse,
    input  logic [`ADDR_W-1:0] target_address,
    input  logic [9:0]         w1,
    input  logic [9:0]         h1,
    input  logic [31:0]        mb_w,
    output logic [`ADDR_W-1:0] m_axi_awaddr,
    output logic [7:0]         m_axi_awlen,
    output logic               m_axi_awvalid,
    input  logic               m_axi_awready,
    output logic               burst_issued,
    output logic               addr_done,
    input  logic               done_pulse
);
    import axi_wr_pkg::*;

    addr_state_t        state_q;
    logic [9:0]         col_q;
    logic [9:0]         row_q;
    logic [9:0]         w1_q;
    logic [9:0]         h1_q;
    logic [`ADDR_W-1:0] stride_q;
    logic [`ADDR_W-1:0] row_base_q;
    logic [`ADDR_W-1:0] addr_q;
    logic               start_ok;
    logic               aw_hs;
    logic               last_col;
    logic               last_row;

    assign start_ok = (state_q == ADDR_IDLE) && start_pulse;
    assign aw_hs    = m_axi_awvalid && m_axi_awready;
    assign last_col = (col_q == w1_q - 10'd1);
    assign last_row = (row_q == h1_q - 10'd1);

    assign m_axi_awaddr  = addr_q;
    assign m_axi_awlen   = 8'(`BURST_LEN - 1);
    assign m_axi_awvalid = (state_q == ADDR_ISSUE);
    assign burst_issued  = aw_hs;
    assign addr_done     = (state_q == ADDR_DRAIN);

    // --------------------
    // Window walk, column first then row
    // --------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state_q <= ADDR_IDLE;
            col_q   <= '0;
            row_q   <= '0;
        end
        else
        begin
            case (state_q)
                ADDR_IDLE:
                begin
                    if (start_pulse)
                    begin
                        state_q <= ADDR_ISSUE;
                        col_q   <= '0;
                        row_q   <= '0;
                    end
                end
                ADDR_ISSUE:
                begin
                    if (aw_hs && last_col)
                    begin
                        col_q <= '0;
                        row_q <= row_q + 10'd1;
                        if (last_row)
                            state_q <= ADDR_DRAIN;
                    end
                    else if (aw_hs)
                        col_q <= col_q + 10'd1;
                end
                // Wait for the last response
                ADDR_DRAIN:
                begin
                    if (done_pulse)
                        state_q <= ADDR_IDLE;
                end
                default: state_q <= ADDR_IDLE;
            endcase
        end
    end

    // Window geometry and running address
    always_ff @(posedge clk)
    begin
        if (start_ok)
        begin
            w1_q       <= w1;
            h1_q       <= h1;
            stride_q   <= `ADDR_W'(mb_w) * `ADDR_W'(`BLOCK_BYTES);
            row_base_q <= target_address;
            addr_q     <= target_address;
        end
        else if (aw_hs && last_col)
        begin
            row_base_q <= row_base_q + stride_q;
            addr_q     <= row_base_q + stride_q;
        end
        else if (aw_hs)
            addr_q <= addr_q + `ADDR_W'(`BLOCK_BYTES);
    end

endmodule

`default_nettype wire

// File: hdl/wdata_channel.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_wr_defs.svh"

module wdata_channel (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 burst_issued,
    input  logic                 fifo_empty,
    input  logic [`DATA_W-1:0]   fifo_dout,
    output logic                 fifo_rd,
    output logic [`DATA_W-1:0]   m_axi_wdata,
    output logic [`DATA_W/8-1:0] m_axi_wstrb,
    output logic                 m_axi_wlast,
    output logic                 m_axi_wvalid,
    input  logic                 m_axi_wready
);

    localparam int BEAT_W = $clog2(`BURST_LEN);
    // Wide enough for a full 1023 x 1023 window
    localparam int PEND_W = 20;

    logic [PEND_W-1:0] pend_q;
    logic [BEAT_W-1:0] beat_q;
    logic              beat_go;
    logic              burst_end;

    // Beats only flow behind an issued address
    assign m_axi_wvalid = !fifo_empty && (pend_q != '0);
    assign m_axi_wlast  = (beat_q == BEAT_W'(`BURST_LEN - 1));
    assign m_axi_wdata  = fifo_dout;
    assign m_axi_wstrb  = '1;

    assign beat_go   = m_axi_wvalid && m_axi_wready;
    assign burst_end = beat_go && m_axi_wlast;
    assign fifo_rd   = beat_go;

    // --------------------
    // Pending bursts and beat position
    // --------------------
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            pend_q <= '0;
            beat_q <= '0;
        end
        else
        begin
            if (burst_issued && !burst_end)
                pend_q <= pend_q + 1'b1;
            else if (burst_end && !burst_issued)
                pend_q <= pend_q - 1'b1;

            if (burst_end)
                beat_q <= '0;
            else if (beat_go)
                beat_q <= beat_q + 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hdl/axi_master_wr.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_wr_defs.svh"

module axi_master_wr (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [31:0]          snap_context,
    input  logic                 start_pulse,
    input  logic [`ADDR_W-1:0]   target_address,
    input  logic [9:0]           w1,
    input  logic [9:0]           h1,
    input  logic [31:0]          mb_w,
    output logic [`ID_W-1:0]     m_axi_awid,
    output logic [`ADDR_W-1:0]   m_axi_awaddr,
    output logic [7:0]           m_axi_awlen,
    output logic [`USER_W-1:0]   m_axi_awuser,
    output logic                 m_axi_awvalid,
    input  logic                 m_axi_awready,
    output logic [`DATA_W-1:0]   m_axi_wdata,
    output logic [`DATA_W/8-1:0] m_axi_wstrb,
    output logic                 m_axi_wlast,
    output logic                 m_axi_wvalid,
    input  logic                 m_axi_wready,
    input  logic [`ID_W-1:0]     m_axi_bid,
    input  axi_wr_pkg::bresp_t   m_axi_bresp,
    input  logic                 m_axi_bvalid,
    input  logic                 fifo_empty,
    input  logic [`DATA_W-1:0]   fifo_dout,
    output logic                 fifo_rd,
    output logic                 done_pulse,
    output logic                 wr_error
);
    import axi_wr_pkg::*;

    localparam int NUM_ID = 1 << `ID_W;
    localparam int OUT_W  = 20;

    logic             burst_sent;
    logic             addr_done;
    logic             all_clear;
    logic [OUT_W-1:0] out_q [NUM_ID];
    logic [OUT_W-1:0] out_nxt [NUM_ID];

    assign m_axi_awuser = snap_context[`USER_W-1:0];

    waddr_channel u_waddr (
        .clk            (clk),
        .rst_n          (rst_n),
        .start_pulse    (start_pulse),
        .target_address (target_address),
        .w1             (w1),
        .h1             (h1),
        .mb_w           (mb_w),
        .m_axi_awaddr   (m_axi_awaddr),
        .m_axi_awlen    (m_axi_awlen),
        .m_axi_awvalid  (m_axi_awvalid),
        .m_axi_awready  (m_axi_awready),
        .burst_issued   (burst_sent),
        .addr_done      (addr_done),
        .done_pulse     (done_pulse)
    );

    wdata_channel u_wdata (
        .clk          (clk),
        .rst_n        (rst_n),
        .burst_issued (burst_sent),
        .fifo_empty   (fifo_empty),
        .fifo_dout    (fifo_dout),
        .fifo_rd      (fifo_rd),
        .m_axi_wdata  (m_axi_wdata),
        .m_axi_wstrb  (m_axi_wstrb),
        .m_axi_wlast  (m_axi_wlast),
        .m_axi_wvalid (m_axi_wvalid),
        .m_axi_wready (m_axi_wready)
    );

    // --------------------
    // Outstanding bursts, counted per ID
    // --------------------
    always_comb
    begin
        all_clear = 1'b1;
        for (int i = 0; i < NUM_ID; i++)
        begin
            out_nxt[i] = out_q[i];
            if (burst_sent && m_axi_awid == `ID_W'(i))
                out_nxt[i] = out_nxt[i] + 1'b1;
            if (m_axi_bvalid && m_axi_bid == `ID_W'(i))
                out_nxt[i] = out_nxt[i] - 1'b1;
            if (out_nxt[i] != '0)
                all_clear = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            m_axi_awid <= '0;
            done_pulse <= 1'b0;
            wr_error   <= 1'b0;
            for (int i = 0; i < NUM_ID; i++)
                out_q[i] <= '0;
        end
        else
        begin
            // Wraps through all IDs
            if (burst_sent)
                m_axi_awid <= m_axi_awid + 1'b1;
            for (int i = 0; i < NUM_ID; i++)
                out_q[i] <= out_nxt[i];
            done_pulse <= m_axi_bvalid && addr_done && all_clear;
            wr_error   <= m_axi_bvalid && (m_axi_bresp != OKAY);
        end
    end

endmodule

`default_nettype wire

// File: hdl/enc_wr_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_wr_defs.svh"

module enc_wr_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 push,
    input  logic [`DATA_W-1:0]   push_data,
    output logic                 full,
    input  logic [31:0]          snap_context,
    input  logic                 start_pulse,
    input  logic [`ADDR_W-1:0]   target_address,
    input  logic [9:0]           w1,
    input  logic [9:0]           h1,
    input  logic [31:0]          mb_w,
    output logic [`ID_W-1:0]     m_axi_awid,
    output logic [`ADDR_W-1:0]   m_axi_awaddr,
    output logic [7:0]           m_axi_awlen,
    output logic [`USER_W-1:0]   m_axi_awuser,
    output logic                 m_axi_awvalid,
    input  logic                 m_axi_awready,
    output logic [`DATA_W-1:0]   m_axi_wdata,
    output logic [`DATA_W/8-1:0] m_axi_wstrb,
    output logic                 m_axi_wlast,
    output logic                 m_axi_wvalid,
    input  logic                 m_axi_wready,
    input  logic [`ID_W-1:0]     m_axi_bid,
    input  axi_wr_pkg::bresp_t   m_axi_bresp,
    input  logic                 m_axi_bvalid,
    output logic                 done_pulse,
    output logic                 wr_error
);

    // --------------------
    // Encoder beat buffer
    // --------------------
    logic               fifo_empty;
    logic               fifo_rd;
    logic [`DATA_W-1:0] fifo_dout;

    block_fifo u_fifo (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (push),
        .push_data  (push_data),
        .full       (full),
        .fifo_rd    (fifo_rd),
        .fifo_dout  (fifo_dout),
        .fifo_empty (fifo_empty)
    );

    axi_master_wr u_master (
        .clk            (clk),
        .rst_n          (rst_n),
        .snap_context   (snap_context),
        .start_pulse    (start_pulse),
        .target_address (target_address),
        .w1             (w1),
        .h1             (h1),
        .mb_w           (mb_w),
        .m_axi_awid     (m_axi_awid),
        .m_axi_awaddr   (m_axi_awaddr),
        .m_axi_awlen    (m_axi_awlen),
        .m_axi_awuser   (m_axi_awuser),
        .m_axi_awvalid  (m_axi_awvalid),
        .m_axi_awready  (m_axi_awready),
        .m_axi_wdata    (m_axi_wdata),
        .m_axi_wstrb    (m_axi_wstrb),
        .m_axi_wlast    (m_axi_wlast),
        .m_axi_wvalid   (m_axi_wvalid),
        .m_axi_wready   (m_axi_wready),
        .m_axi_bid      (m_axi_bid),
        .m_axi_bresp    (m_axi_bresp),
        .m_axi_bvalid   (m_axi_bvalid),
        .fifo_empty     (fifo_empty),
        .fifo_dout      (fifo_dout),
        .fifo_rd        (fifo_rd),
        .done_pulse     (done_pulse),
        .wr_error       (wr_error)
    );

endmodule

`default_nettype wire

// File: dv/axi_mem_model.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_wr_defs.svh"

module axi_mem_model (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 stall_en,
    input  int                   err_burst,
    input  logic [`ID_W-1:0]     awid,
    input  logic [`ADDR_W-1:0]   awaddr,
    input  logic [7:0]           awlen,
    input  logic [`USER_W-1:0]   awuser,
    input  logic                 awvalid,
    output logic                 awready,
    input  logic [`DATA_W-1:0]   wdata,
    input  logic [`DATA_W/8-1:0] wstrb,
    input  logic                 wlast,
    input  logic                 wvalid,
    output logic                 wready,
    output logic [`ID_W-1:0]     bid,
    output axi_wr_pkg::bresp_t   bresp,
    output logic                 bvalid
);
    import axi_wr_pkg::*;

    int                 seed;
    int                 beat_idx;
    int                 burst_cnt;
    int                 resp_cnt;
    int                 beat_errs;
    logic [`DATA_W-1:0] store [logic [`ADDR_W-1:0]];
    logic [`ADDR_W-1:0] aw_addr_log [$];
    logic [`ID_W-1:0]   aw_id_log [$];
    logic [`USER_W-1:0] aw_user_log [$];
    logic [7:0]         aw_len_log [$];
    logic [`ADDR_W-1:0] data_addr_q [$];
    logic [`ID_W-1:0]   data_id_q [$];
    logic [`ID_W-1:0]   resp_id_q [$];
    bresp_t             resp_code_q [$];

    initial
    begin
        seed      = 93827;
        beat_idx  = 0;
        burst_cnt = 0;
        resp_cnt  = 0;
        beat_errs = 0;
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        bid       = '0;
        bresp     = OKAY;
    end

    // Roughly one stall in four when enabled
    function automatic logic stall_now();
        return stall_en && (($random(seed) & 3) == 0);
    endfunction

    function automatic logic [`DATA_W-1:0] read_beat(input logic [`ADDR_W-1:0] addr);
        if (store.exists(addr))
            return store[addr];
        return '1;
    endfunction

    // --------------------
    // Handshakes are decided here and complete at the next rising edge
    // --------------------
    always @(negedge clk)
    begin
        if (!rst_n)
        begin
            awready = 1'b0;
            wready  = 1'b0;
            bvalid  = 1'b0;
        end
        else
        begin
            // In-order responses
            bvalid = 1'b0;
            if (resp_id_q.size() != 0 && !stall_now())
            begin
                bvalid = 1'b1;
                bid    = resp_id_q.pop_front();
                bresp  = resp_code_q.pop_front();
                resp_cnt++;
            end

            awready = !stall_now();
            if (awvalid && awready)
            begin
                aw_addr_log.push_back(awaddr);
                aw_id_log.push_back(awid);
                aw_user_log.push_back(awuser);
                aw_len_log.push_back(awlen);
                data_addr_q.push_back(awaddr);
                data_id_q.push_back(awid);
            end

            wready = !stall_now();
            if (wvalid && wready)
            begin
                // A beat with no address ahead of it is a protocol error
                if (data_addr_q.size() == 0)
                    beat_errs++;
                else
                begin
                    store[data_addr_q[0] + `ADDR_W'(beat_idx * (`DATA_W / 8))] = wdata;
                    if (wlast != (beat_idx == `BURST_LEN - 1) || wstrb != '1)
                        beat_errs++;
                    beat_idx++;
                    if (beat_idx == `BURST_LEN)
                    begin
                        beat_idx = 0;
                        void'(data_addr_q.pop_front());
                        resp_id_q.push_back(data_id_q.pop_front());
                        resp_code_q.push_back((burst_cnt == err_burst) ? SLVERR : OKAY);
                        burst_cnt++;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_enc_wr.sv
`timescale 1ns/1ps
`default_nettype none
`include "axi_wr_defs.svh"

module tb_enc_wr;
    import axi_wr_pkg::*;

    localparam int TOTAL_BEATS = 4 + 24 + 24 + 20 + 16 + 24;
    localparam int CYCLE_LIMIT = TOTAL_BEATS * 8 + 2000;

    logic                 clk;
    logic                 rst_n;
    logic                 push;
    logic [`DATA_W-1:0]   push_data;
    logic                 full;
    logic [31:0]          snap_context;
    logic                 start_pulse;
    logic [`ADDR_W-1:0]   target_address;
    logic [9:0]           w1;
    logic [9:0]           h1;
    logic [31:0]          mb_w;
    logic [`ID_W-1:0]     m_axi_awid;
    logic [`ADDR_W-1:0]   m_axi_awaddr;
    logic [7:0]           m_axi_awlen;
    logic [`USER_W-1:0]   m_axi_awuser;
    logic                 m_axi_awvalid;
    logic                 m_axi_awready;
    logic [`DATA_W-1:0]   m_axi_wdata;
    logic [`DATA_W/8-1:0] m_axi_wstrb;
    logic                 m_axi_wlast;
    logic                 m_axi_wvalid;
    logic                 m_axi_wready;
    logic [`ID_W-1:0]     m_axi_bid;
    bresp_t               m_axi_bresp;
    logic                 m_axi_bvalid;
    logic                 done_pulse;
    logic                 wr_error;
    logic                 stall_en;
    int                   err_burst;

    logic [`DATA_W-1:0] push_q [$];
    int                 beat_cnt;
    int                 burst_total;
    int                 next_id;
    int                 err_count;
    int                 cycles;
    int                 done_cnt;
    int                 err_pulses;
    int                 resp_seen;
    logic               exp_err;

    enc_wr_top UUT (
        .clk (clk), .rst_n (rst_n), .push (push), .push_data (push_data), .full (full),
        .snap_context (snap_context), .start_pulse (start_pulse),
        .target_address (target_address), .w1 (w1), .h1 (h1), .mb_w (mb_w),
        .m_axi_awid (m_axi_awid), .m_axi_awaddr (m_axi_awaddr), .m_axi_awlen (m_axi_awlen),
        .m_axi_awuser (m_axi_awuser), .m_axi_awvalid (m_axi_awvalid),
        .m_axi_awready (m_axi_awready), .m_axi_wdata (m_axi_wdata),
        .m_axi_wstrb (m_axi_wstrb), .m_axi_wlast (m_axi_wlast), .m_axi_wvalid (m_axi_wvalid),
        .m_axi_wready (m_axi_wready), .m_axi_bid (m_axi_bid), .m_axi_bresp (m_axi_bresp),
        .m_axi_bvalid (m_axi_bvalid), .done_pulse (done_pulse), .wr_error (wr_error)
    );

    axi_mem_model slave (
        .clk (clk), .rst_n (rst_n), .stall_en (stall_en), .err_burst (err_burst),
        .awid (m_axi_awid), .awaddr (m_axi_awaddr), .awlen (m_axi_awlen),
        .awuser (m_axi_awuser), .awvalid (m_axi_awvalid), .awready (m_axi_awready),
        .wdata (m_axi_wdata), .wstrb (m_axi_wstrb), .wlast (m_axi_wlast),
        .wvalid (m_axi_wvalid), .wready (m_axi_wready),
        .bid (m_axi_bid), .bresp (m_axi_bresp), .bvalid (m_axi_bvalid)
    );

    always #20 clk = ~clk;

    task automatic stop_on_failure();
        $display(">>> FAIL");
        $fatal(1);
    endtask

    task automatic expect_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp)
        begin
            err_count++;
            $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
            stop_on_failure();
        end
    endtask

    // --------------------
    // Monitors
    // --------------------
    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("Timeout: the write run did not finish within %0d cycles", CYCLE_LIMIT);
            stop_on_failure();
        end
    end

    // Responses come back in burst order, so the injected one is known by its index
    always @(posedge clk)
    begin
        exp_err <= rst_n && m_axi_bvalid && (resp_seen == err_burst);
        if (rst_n && m_axi_bvalid)
            resp_seen++;
        if (rst_n)
            expect_eq("m_axi_wlast/wstrb errors", 64'(slave.beat_errs), 64'd0);
    end

    always @(negedge clk)
    begin
        if (rst_n)
        begin
            expect_eq("wr_error", 64'(wr_error), 64'(exp_err));
            if (done_pulse)
                done_cnt++;
            if (wr_error)
                err_pulses++;
        end
    end

    // --------------------
    // Stimulus
    // --------------------
    task automatic push_beats(input int count, input int mid_at);
        int i;
        for (i = 0; i < count; i++)
        begin
            @(negedge clk);
            push        = 1'b0;
            start_pulse = 1'b0;
            while (full)
                @(negedge clk);
            push      = 1'b1;
            push_data = {32'(beat_cnt), 32'(~beat_cnt)};
            push_q.push_back(push_data);
            beat_cnt++;
            // Restart attempt with a different window while busy
            if (i == mid_at)
            begin
                start_pulse    = 1'b1;
                target_address = target_address + 32'h0001_0000;
                w1             = 10'd1;
            end
        end
        @(negedge clk);
        push        = 1'b0;
        start_pulse = 1'b0;
    endtask

    task automatic wait_done();
        @(negedge clk);
        while (!done_pulse)
            @(negedge clk);
    endtask

    task automatic run_window(input logic [31:0] base, input int w, input int h,
                              input int stride, input logic [31:0] ctx,
                              input int err_at, input int mid_at, input logic prefill);
        int          blocks;
        int          first_log;
        int          first_beat;
        int          done0;
        int          errs0;
        int          blk;
        int          b;
        logic [31:0] addr;
        blocks     = w * h;
        first_log  = slave.aw_addr_log.size();
        first_beat = push_q.size();
        done0      = done_cnt;
        errs0      = err_pulses;
        // No address yet, so nothing drains the FIFO
        if (prefill)
        begin
            push_beats(`FIFO_DEPTH, -1);
            expect_eq("full", 64'(full), 64'd1);
        end
        @(negedge clk);
        target_address = base;
        w1             = 10'(w);
        h1             = 10'(h);
        mb_w           = 32'(stride);
        snap_context   = ctx;
        err_burst      = (err_at < 0) ? -1 : burst_total + err_at;
        start_pulse    = 1'b1;
        @(negedge clk);
        start_pulse = 1'b0;
        expect_eq("m_axi_awvalid", 64'(m_axi_awvalid), 64'd1);
        push_beats(blocks * `BURST_LEN - (prefill ? `FIFO_DEPTH : 0), mid_at);
        wait_done();
        repeat (10) @(negedge clk);

        expect_eq("address count", 64'(slave.aw_addr_log.size() - first_log), 64'(blocks));
        for (blk = 0; blk < blocks; blk++)
        begin
            addr = base + 32'(((blk / w) * stride + (blk % w)) * `BLOCK_BYTES);
            expect_eq("m_axi_awaddr", 64'(slave.aw_addr_log[first_log + blk]), 64'(addr));
            expect_eq("m_axi_awlen", 64'(slave.aw_len_log[first_log + blk]),
                      64'(`BURST_LEN - 1));
            expect_eq("m_axi_awid", 64'(slave.aw_id_log[first_log + blk]), 64'(next_id));
            next_id = (next_id + 1) % (1 << `ID_W);
            expect_eq("m_axi_awuser", 64'(slave.aw_user_log[first_log + blk]),
                      64'(ctx[`USER_W-1:0]));
            for (b = 0; b < `BURST_LEN; b++)
                expect_eq("m_axi_wdata", slave.read_beat(addr + 32'(b * (`DATA_W / 8))),
                          push_q[first_beat + blk * `BURST_LEN + b]);
        end
        expect_eq("done_pulse count", 64'(done_cnt - done0), 64'd1);
        expect_eq("wr_error count", 64'(err_pulses - errs0), (err_at < 0) ? 64'd0 : 64'd1);
        expect_eq("response count", 64'(slave.resp_cnt), 64'(burst_total + blocks));
        burst_total += blocks;
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic single_block();
        stall_en = 1'b0;
        run_window(32'h1000_0000, 1, 1, 1, 32'hCAFE_0011, -1, -1, 1'b0);
    endtask

    task automatic plain_window();
        stall_en = 1'b0;
        run_window(32'h2000_0000, 3, 2, 5, 32'h0000_0022, -1, -1, 1'b1);
    endtask

    task automatic stalled_window();
        stall_en = 1'b1;
        run_window(32'h3000_0100, 3, 2, 5, 32'h1234_5633, -1, -1, 1'b0);
    endtask

    task automatic id_wrap();
        stall_en = 1'b0;
        run_window(32'h4000_0000, 5, 1, 8, 32'h89AB_CDEF, -1, -1, 1'b0);
    endtask

    task automatic slave_error();
        stall_en = 1'b1;
        run_window(32'h5000_0000, 2, 2, 3, 32'h0000_0055, 2, -1, 1'b0);
    endtask

    task automatic ignored_restart();
        stall_en = 1'b0;
        run_window(32'h6000_0040, 3, 2, 4, 32'h0000_0066, -1, 9, 1'b0);
    endtask

    initial
    begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        push           = 1'b0;
        push_data      = '0;
        snap_context   = '0;
        start_pulse    = 1'b0;
        target_address = '0;
        w1             = '0;
        h1             = '0;
        mb_w           = '0;
        stall_en       = 1'b0;
        err_burst      = -1;
        beat_cnt       = 0;
        burst_total    = 0;
        next_id        = 0;
        err_count      = 0;
        cycles         = 0;
        done_cnt       = 0;
        err_pulses     = 0;
        resp_seen      = 0;
        exp_err        = 1'b0;
        repeat (10) @(negedge clk);
        rst_n = 1'b1;
        repeat (2) @(negedge clk);

        single_block();
        plain_window();
        stalled_window();
        id_wrap();
        slave_error();
        ignored_restart();

        if (err_count == 0)
        begin
            $display(">>> PASS");
            $finish;
        end
        else
            stop_on_failure();
    end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
hdl/axi_wr_pkg.sv
hdl/block_fifo.sv
hdl/waddr_channel.sv
hdl/wdata_channel.sv
hdl/axi_master_wr.sv
hdl/enc_wr_top.sv
dv/axi_mem_model.sv
dv/tb_enc_wr.sv

// File: Makefile
# Verilator build and run for the encoder write subsystem

VERILATOR ?= verilator
TOP       ?= tb_enc_wr
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timescale 1ns/1ps -Wno-fatal

BIN  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard hdl/*.sv dv/*.sv include/*.svh) $(FILELIST)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
